//--- verilog/multicore_pkg.sv
package multicore_pkg;

	localparam int num_cores = 4;
	localparam int core_id_w = 2;
	localparam int stage_w = core_id_w + 1;  // one more than an index, counts past the last core

	localparam int frame_len = 8;
	localparam int cnt_w = $clog2(frame_len);

	localparam int sample_w = 19;
	localparam int weight_w = 9;
	localparam int prod_w = sample_w + weight_w;
	localparam int result_w = 28;
	localparam int acc_w = 32;  // 8 full-scale products fit with room

	localparam int reset_gap = 14;
	localparam int gap_cnt_w = $clog2(reset_gap + 1);

	// clamp range of a result
	localparam logic signed [result_w-1:0] result_max = {1'b0, {(result_w - 1){1'b1}}};
	localparam logic signed [result_w-1:0] result_min = {1'b1, {(result_w - 1){1'b0}}};

	// one row per core, indexed by sample position
	// every row sums to more than 512 in magnitude, so full-scale frames clamp
	localparam logic signed [weight_w-1:0] weight_rom [num_cores][frame_len] = '{
		'{
			9'sd120, 9'sd95, 9'sd64, 9'sd33,
			9'sd77, 9'sd101, 9'sd55, 9'sd90
		},
		'{
			-9'sd110, -9'sd80, 9'sd40, -9'sd95,
			-9'sd120, -9'sd72, 9'sd12, -9'sd100
		},
		'{
			9'sd200, -9'sd30, 9'sd150, -9'sd45,
			9'sd90, 9'sd60, -9'sd20, 9'sd130
		},
		'{
			-9'sd150, 9'sd70, -9'sd200, -9'sd60,
			-9'sd30, -9'sd90, 9'sd25, -9'sd110
		}
	};

endpackage

//--- verilog/core_if.sv
`timescale 1ns/1ps

// result stream of one neuron core towards the collector
interface core_if import multicore_pkg::*; ();

	logic signed [result_w-1:0] result;
	logic valid;       // result pending
	logic ready;       // taken this cycle
	logic frame_seen;  // core out of reset

	modport core (
		output result,
		output valid,
		output frame_seen,
		input ready
	);

	modport collector (
		input result,
		input valid,
		input frame_seen,
		output ready
	);

endinterface

//--- verilog/reset_sequencer.sv
`timescale 1ns/1ps

module reset_sequencer import multicore_pkg::*; (
	input logic clk,
	input logic reset,
	output logic [num_cores-1:0] core_reset
);

	logic [gap_cnt_w-1:0] gap_cnt;
	logic [stage_w-1:0] stage;  // next core to release
	logic done;

	assign done = (stage == stage_w'(num_cores));

	// core k leaves reset reset_gap*(k+1) edges after the global reset drops
	always_ff @(posedge clk) begin
		if (reset) begin
			gap_cnt <= '0;
			stage <= '0;
			core_reset <= '1;
		end else if (!done) begin
			if (gap_cnt == gap_cnt_w'(reset_gap)) begin
				core_reset[stage[core_id_w-1:0]] <= 1'b0;
				stage <= stage + 1'b1;
				gap_cnt <= gap_cnt_w'(1);  // this edge opens the next gap
			end else begin
				gap_cnt <= gap_cnt + 1'b1;
			end
		end
	end

endmodule

//--- verilog/neuron_core.sv
`timescale 1ns/1ps

module neuron_core import multicore_pkg::*; #(
	parameter int core_index = 0
) (
	input logic clk,
	input logic reset,
	input logic signed [sample_w-1:0] in_data,
	input logic in_take,
	input logic in_last,
	core_if.core res
);

	logic [cnt_w-1:0] cnt;  // sample position, zero while idle
	logic busy;             // inside a frame this core takes part in
	logic seen_last;        // a frame end passed since release
	logic alive;
	logic valid_q;
	logic signed [result_w-1:0] result_q;
	logic signed [acc_w-1:0] acc;
	logic signed [acc_w-1:0] sum;
	logic signed [weight_w-1:0] weight;
	logic signed [prod_w-1:0] product;
	logic signed [result_w-1:0] sat;
	logic join_frame;
	logic step;

	assign weight = weight_rom[core_index][cnt];
	assign product = in_data * weight;

	// a frame under way at release is skipped up to its last sample
	assign join_frame = !busy && seen_last && !valid_q;
	assign step = alive && in_take && (busy || join_frame);

	// first sample of a frame starts from zero
	assign sum = (busy ? acc : acc_w'(0)) + acc_w'(product);

	always_comb begin
		sat = sum[result_w-1:0];
		if (sum > result_max)
			sat = result_max;
		else if (sum < result_min)
			sat = result_min;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			cnt <= '0;
			busy <= 1'b0;
			seen_last <= 1'b0;
			alive <= 1'b0;
			valid_q <= 1'b0;
		end else begin
			alive <= 1'b1;  // one edge after release, in step with cores_active
			if (alive && in_take && in_last)
				seen_last <= 1'b1;
			if (step) begin
				if (in_last) begin
					busy <= 1'b0;
					cnt <= '0;
					valid_q <= 1'b1;
				end else begin
					busy <= 1'b1;
					cnt <= cnt + 1'b1;
				end
			end else if (valid_q && res.ready) begin
				valid_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (step) begin
			acc <= sum;
			if (in_last)
				result_q <= sat;  // held until taken
		end
	end

	assign res.result = result_q;
	assign res.valid = valid_q;
	assign res.frame_seen = !reset;

endmodule

//--- verilog/result_collector.sv
`timescale 1ns/1ps

module result_collector import multicore_pkg::*; (
	input logic clk,
	input logic reset,
	core_if.collector cores [num_cores],
	output logic out_valid,
	output logic signed [result_w-1:0] out_data,
	output logic [core_id_w-1:0] out_core,
	input logic out_ready,
	output logic in_ready,
	output logic [num_cores-1:0] cores_active
);

	logic [num_cores-1:0] valid_vec;
	logic [num_cores-1:0] seen_vec;
	logic [num_cores-1:0] grant;
	logic signed [result_w-1:0] result_arr [num_cores];
	logic [core_id_w-1:0] sel;

	for (genvar i = 0; i < num_cores; i++) begin : g_port
		assign valid_vec[i] = cores[i].valid;
		assign seen_vec[i] = cores[i].frame_seen;
		assign result_arr[i] = cores[i].result;
		assign cores[i].ready = grant[i] & out_ready;  // only the selected core
	end

	// scan from the top so the lowest pending index wins
	always_comb begin
		sel = '0;
		grant = '0;
		for (int i = num_cores - 1; i >= 0; i--) begin
			if (valid_vec[i]) begin
				sel = core_id_w'(i);
				grant = '0;
				grant[i] = 1'b1;
			end
		end
	end

	assign out_valid = |valid_vec;
	assign out_data = result_arr[sel];
	assign out_core = sel;

	// no new frame until every result of the last one is out
	assign in_ready = ~|valid_vec;

	always_ff @(posedge clk) begin
		if (reset)
			cores_active <= '0;
		else
			cores_active <= seen_vec;
	end

endmodule

//--- verilog/multicore.sv
`timescale 1ns/1ps

module multicore import multicore_pkg::*; (
	input logic clk,
	input logic reset,
	input logic in_valid,
	input logic signed [sample_w-1:0] in_data,
	input logic in_last,
	output logic in_ready,
	output logic out_valid,
	output logic signed [result_w-1:0] out_data,
	output logic [core_id_w-1:0] out_core,
	input logic out_ready,
	output logic [num_cores-1:0] cores_active
);

	logic [num_cores-1:0] core_reset;
	logic in_take;  // sample transfer, seen by every core

	core_if res_if [num_cores] ();

	assign in_take = in_valid & in_ready;

	reset_sequencer u_seq (
		.clk(clk),
		.reset(reset),
		.core_reset(core_reset)
	);

	for (genvar i = 0; i < num_cores; i++) begin : g_core
		neuron_core #(
			.core_index(i)
		) u_core (
			.clk(clk),
			.reset(core_reset[i]),
			.in_data(in_data),
			.in_take(in_take),
			.in_last(in_last),
			.res(res_if[i])
		);
	end

	result_collector u_coll (
		.clk(clk),
		.reset(reset),
		.cores(res_if),
		.out_valid(out_valid),
		.out_data(out_data),
		.out_core(out_core),
		.out_ready(out_ready),
		.in_ready(in_ready),
		.cores_active(cores_active)
	);

endmodule

//--- tb/multicore_asserts.sv
`timescale 1ns/1ps

module multicore_asserts import multicore_pkg::*; (
	input logic clk,
	input logic reset,
	input logic in_ready,
	input logic out_valid,
	input logic signed [result_w-1:0] out_data,
	input logic [core_id_w-1:0] out_core,
	input logic out_ready,
	input logic [num_cores-1:0] cores_active
);

	int fail_count = 0;

	// stalled output keeps core and data
	hold_stable: assert property (@(posedge clk) disable iff (reset)
		out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_core))
		else begin
			$error("output changed while stalled");
			fail_count++;
		end

	// input opens again only after the last pending result leaves
	input_held_until_taken: assert property (@(posedge clk) disable iff (reset)
		$rose(in_ready) |-> $past(reset) || $past(out_valid && out_ready))
		else begin
			$error("input reopened while a result was still pending");
			fail_count++;
		end

	source_active: assert property (@(posedge clk) disable iff (reset)
		out_valid |-> cores_active[out_core])
		else begin
			$error("result from a core that is not active");
			fail_count++;
		end

	// bits only rise between resets
	active_grows: assert property (@(posedge clk) disable iff (reset)
		($past(cores_active) & ~cores_active) == '0)
		else begin
			$error("cores_active lost a bit without reset");
			fail_count++;
		end

endmodule

//--- tb/multicore_tb.sv
`timescale 1ns/1ps

module multicore_tb import multicore_pkg::*; ();

	localparam int clk_period = 40;
	localparam int rel_frames = 6;   // frames sent while cores are released
	localparam int full_frames = 4;
	localparam int rand_frames = 6;
	localparam int num_frames = 2 * rel_frames + full_frames + 2 + rand_frames + 1;
	localparam int release_cycles = reset_gap * num_cores + 4;
	localparam int timeout_cycles = num_frames * (frame_len + num_cores + 40)
		+ 3 * release_cycles;
	localparam int drain_limit = 200;

	logic clk;
	logic reset;
	logic in_valid;
	logic signed [sample_w-1:0] in_data;
	logic in_last;
	logic in_ready;
	logic out_valid;
	logic signed [result_w-1:0] out_data;
	logic [core_id_w-1:0] out_core;
	logic out_ready;
	logic [num_cores-1:0] cores_active;

	integer seed = 32'h256b8378;
	int value_errors = 0;
	int other_errors = 0;
	int checks = 0;
	int results_seen = 0;
	int rel_cnt = 0;     // saturating count of posedges since reset fell
	int ready_mode = 0;  // 0 always ready, 1 random, 2 held low
	logic [num_cores-1:0] prev_last_active;
	logic signed [sample_w-1:0] frame_buf [frame_len];
	logic [core_id_w-1:0] exp_core_q [$];
	logic signed [result_w-1:0] exp_data_q [$];

	multicore DUT (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_data(in_data),
		.in_last(in_last),
		.in_ready(in_ready),
		.out_valid(out_valid),
		.out_data(out_data),
		.out_core(out_core),
		.out_ready(out_ready),
		.cores_active(cores_active)
	);

	bind multicore multicore_asserts u_asserts (
		.clk(clk),
		.reset(reset),
		.in_ready(in_ready),
		.out_valid(out_valid),
		.out_data(out_data),
		.out_core(out_core),
		.out_ready(out_ready),
		.cores_active(cores_active)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	// saturated dot product of one frame with one weight row
	function automatic logic signed [result_w-1:0] ref_dot(
		input logic signed [sample_w-1:0] smp [frame_len],
		input int row
	);
		longint sum;
		sum = 0;
		for (int i = 0; i < frame_len; i++)
			sum += longint'(smp[i]) * longint'(weight_rom[row][i]);
		if (sum > longint'(result_max))
			return result_max;
		if (sum < longint'(result_min))
			return result_min;
		return result_w'(sum);
	endfunction

	// core k reset drops at edge 1 + reset_gap*(k+1) and its status bit one edge later
	function automatic logic [num_cores-1:0] active_mask(input int edges);
		logic [num_cores-1:0] m;
		m = '0;
		for (int k = 0; k < num_cores; k++)
			if (edges >= reset_gap * (k + 1) + 2)
				m[k] = 1'b1;
		return m;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			value_errors++;
			$display("FAILED %s: got %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic apply_reset();
		reset = 1'b1;
		in_valid = 1'b0;
		in_last = 1'b0;
		exp_core_q.delete();  // pending results are dropped by reset
		exp_data_q.delete();
		prev_last_active = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		check_value("out_valid", 32'(out_valid), 32'd0);
		check_value("in_ready", 32'(in_ready), 32'd1);
		check_value("cores_active", 32'(cores_active), 32'd0);
		reset = 1'b0;
	endtask

	// kind 0 random, 1 all max, 2 all min
	task automatic send_frame(input int kind, input bit gaps);
		logic [num_cores-1:0] first_active;
		logic [num_cores-1:0] mask;
		for (int i = 0; i < frame_len; i++) begin
			case (kind)
				1: frame_buf[i] = {1'b0, {(sample_w - 1){1'b1}}};
				2: frame_buf[i] = {1'b1, {(sample_w - 1){1'b0}}};
				default: frame_buf[i] = sample_w'($random(seed));
			endcase
		end
		first_active = '0;
		for (int i = 0; i < frame_len; i++) begin
			if (gaps && ($random(seed) % 3) == 0) begin
				in_valid = 1'b0;
				in_last = 1'b0;
				@(negedge clk);
			end
			in_valid = 1'b1;
			in_data = frame_buf[i];
			in_last = (i == frame_len - 1);
			while (!in_ready)
				@(negedge clk);
			if (i == 0)
				first_active = cores_active;
			if (i == frame_len - 1) begin
				// a core needs a full frame end behind it before it joins
				mask = first_active & prev_last_active;
				for (int c = 0; c < num_cores; c++) begin
					if (mask[c]) begin
						exp_core_q.push_back(core_id_w'(c));
						exp_data_q.push_back(ref_dot(frame_buf, c));
					end
				end
				prev_last_active = cores_active;
			end
			@(negedge clk);
		end
		in_valid = 1'b0;
		in_last = 1'b0;
	endtask

	task automatic drain();
		for (int n = 0; n < drain_limit && (exp_core_q.size() != 0 || out_valid); n++)
			@(negedge clk);
		if (exp_core_q.size() != 0) begin
			other_errors++;
			$display("ERROR: %0d expected results never came out", exp_core_q.size());
			exp_core_q.delete();
			exp_data_q.delete();
		end
	endtask

	always @(posedge clk) begin
		if (reset)
			rel_cnt <= 0;
		else if (rel_cnt < 1000)
			rel_cnt <= rel_cnt + 1;
	end

	initial begin
		out_ready = 1'b0;
		forever begin
			@(negedge clk);
			case (ready_mode)
				0: out_ready = 1'b1;
				1: out_ready = ($random(seed) % 4) != 0;  // ready about 3 in 4
				default: out_ready = 1'b0;
			endcase
		end
	end

	// release order checked every cycle
	initial begin
		@(posedge clk);
		forever begin
			@(negedge clk);
			#5;
			check_value("cores_active", 32'(cores_active), 32'(active_mask(rel_cnt)));
		end
	end

	initial begin : compare_outputs
		logic [core_id_w-1:0] exp_c;
		logic signed [result_w-1:0] exp_d;
		forever begin
			@(negedge clk);
			#5;  // outputs and out_ready settled until the next posedge
			if (!reset && out_valid && out_ready) begin
				if (exp_core_q.size() == 0) begin
					other_errors++;
					$display("ERROR: core %0d sent a result that was not expected at %0t",
						out_core, $time);
				end else begin
					exp_c = exp_core_q.pop_front();
					exp_d = exp_data_q.pop_front();
					check_value("out_core", 32'(out_core), 32'(exp_c));
					check_value("out_data", 32'(out_data), 32'(exp_d));
					results_seen++;
				end
			end
		end
	end

	initial begin
		repeat (timeout_cycles) @(posedge clk);
		$display("ERROR: timeout, the run did not end within %0d cycles", timeout_cycles);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		reset = 1'b1;
		in_valid = 1'b0;
		in_data = '0;
		in_last = 1'b0;
		prev_last_active = '0;
		apply_reset();

		// frames during the staggered release
		for (int f = 0; f < rel_frames; f++)
			send_frame(0, 1'b0);
		while (cores_active != '1)
			@(negedge clk);

		for (int f = 0; f < full_frames; f++)
			send_frame(0, 1'b0);
		send_frame(1, 1'b0);
		send_frame(2, 1'b0);
		drain();

		// output stalls and input gaps
		ready_mode <= 1;
		for (int f = 0; f < rand_frames; f++)
			send_frame(0, 1'b1);
		ready_mode <= 0;
		drain();

		// second reset with results still waiting
		ready_mode <= 2;
		@(negedge clk);
		send_frame(0, 1'b0);
		repeat (2) @(negedge clk);
		check_value("out_valid", 32'(out_valid), 32'd1);
		check_value("in_ready", 32'(in_ready), 32'd0);
		apply_reset();
		ready_mode <= 0;
		for (int f = 0; f < rel_frames; f++)
			send_frame(0, 1'b0);
		drain();
		@(negedge clk);

		if (results_seen == 0) begin
			other_errors++;
			$display("ERROR: no result was ever sent out");
		end
		$display("checks %0d, results %0d, value errors %0d, other errors %0d, %s %0d",
			checks, results_seen, value_errors, other_errors,
			"assertion failures", DUT.u_asserts.fail_count);
		if (value_errors == 0 && other_errors == 0 && DUT.u_asserts.fail_count == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

//--- filelist.f
verilog/multicore_pkg.sv
verilog/core_if.sv
verilog/reset_sequencer.sv
verilog/neuron_core.sv
verilog/result_collector.sv
verilog/multicore.sv
tb/multicore_asserts.sv
tb/multicore_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the multicore testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log
obj=obj_dir

verilator --binary --timing --assert -Wno-fatal \
	-f filelist.f --top-module multicore_tb -Mdir "$obj"
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$obj/Vmulticore_tb" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Simulation completed successfully$" "$log"; then
	echo "PASS"
	exit 0
fi

echo "FAIL"
exit 1
